// File: source/gps_cmd_pkg.sv
package gps_cmd_pkg;

    // Kind of host transfer carried with each request
    typedef enum logic [1:0] {
        wr_reg,
        rd_reg,
        rd_bit,
        wr_evt
    } cmd_kind_e;

    // Bit positions in the one-hot op word
    // Read selects sit in the low three bits so they double as ser_sel
    localparam int GET_CHAN_IQ  = 0;
    localparam int GET_SRQ      = 1;
    localparam int GET_SNAPSHOT = 2;
    localparam int SET_CHAN     = 3;
    localparam int SET_MASK     = 4;
    localparam int SET_PAUSE    = 5;
    localparam int SET_CODE     = 6;
    localparam int CHAN_RST     = 7;

    // Host side view of the argument word
    typedef struct packed {
        logic [11:0] pause;
        logic [15:0] mask;
        logic [3:0]  chan;
    } cmd_sel_t;

    // Channel side view of the same word
    typedef struct packed {
        logic [15:0] rsvd;
        logic [5:0]  dwell;     // chips per code step, minus one
        logic [9:0]  init;      // initial LFSR state
    } cmd_code_t;

    typedef union packed {
        cmd_sel_t  sel;
        cmd_code_t code;
    } cmd_word_u;

endpackage

// File: source/gps_chan_pkg.sv
package gps_chan_pkg;

    // Chips in one code epoch, the period of a 10 bit maximal LFSR
    localparam int CODE_LEN = 1023;

    // Integrate-and-dump accumulator width
    localparam int ACC_W = 16;

    // System tick counter width
    localparam int TICK_W = 32;

    typedef logic signed [ACC_W-1:0] acc_t;

    typedef logic [TICK_W-1:0] tick_t;

endpackage

// File: source/gps_host_if.sv
`timescale 1ns/1ps

module gps_host_if (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  gps_cmd_pkg::cmd_kind_e kind,
    input  logic [15:0]            op,
    input  gps_cmd_pkg::cmd_word_u tos,
    output logic                   ack,
    output logic [3:0]             cmd_chan,
    output logic [15:0]            chan_mask,
    output logic                   pause_load,
    output logic [11:0]            pause_cnt,
    output logic [15:0]            chan_wr,
    output logic [15:0]            chan_rst,
    output logic                   srq_load,
    output logic                   snap_load,
    output logic                   iq_load,
    output logic                   bit_next,
    output logic [15:0]            chan_shift,
    output logic [2:0]             ser_sel
);
    import gps_cmd_pkg::*;

    logic        fire;
    logic        fired;
    logic        wr_stb;
    logic        rd_stb;
    logic        bit_stb;
    logic        evt_stb;
    logic [15:0] chan_onehot;

    ////////////////////////////////////////////////////////////
    // Four-phase handshake

    // New request seen, only once per req high period
    assign fire = req && !ack && !fired;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fired   <= 1'b0;
            ack     <= 1'b0;
            wr_stb  <= 1'b0;
            rd_stb  <= 1'b0;
            bit_stb <= 1'b0;
            evt_stb <= 1'b0;
        end else begin
            // Held until the host drops req
            fired   <= req && (fired || fire);
            // Rises with the register effect, falls after req low
            ack     <= req && fired;
            // One strobe set per handshake
            wr_stb  <= fire && (kind == wr_reg);
            rd_stb  <= fire && (kind == rd_reg);
            bit_stb <= fire && (kind == rd_bit);
            evt_stb <= fire && (kind == wr_evt);
        end
    end

    ////////////////////////////////////////////////////////////
    // Command registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_chan  <= '0;
            chan_mask <= '0;
            ser_sel   <= '0;
        end else begin
            // Read select kept for the rd_bit transfers that follow
            if (fire && kind == rd_reg)
                ser_sel <= op[2:0];
            if (wr_stb && op[SET_CHAN])
                cmd_chan <= tos.sel.chan;
            if (wr_stb && op[SET_MASK])
                chan_mask <= tos.sel.mask;
        end
    end

    // Pause count goes straight to the timebase with its load pulse
    assign pause_cnt  = tos.sel.pause;
    assign pause_load = wr_stb && op[SET_PAUSE];

    // Read loads
    assign srq_load  = rd_stb && op[GET_SRQ];
    assign snap_load = rd_stb && op[GET_SNAPSHOT];
    assign iq_load   = rd_stb && op[GET_CHAN_IQ];
    assign bit_next  = bit_stb;

    ////////////////////////////////////////////////////////////
    // Channel steering

    assign chan_onehot = 16'b1 << cmd_chan;

    assign chan_wr    = wr_stb ? chan_onehot : '0;
    assign chan_shift = (bit_stb && ser_sel[GET_CHAN_IQ]) ? chan_onehot : '0;
    // Reset hits every channel enabled in the mask
    assign chan_rst   = (evt_stb && op[CHAN_RST]) ? chan_mask : '0;

endmodule

// File: source/gps_timebase.sv
`timescale 1ns/1ps

module gps_timebase (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pause_load,
    input  logic [11:0]         pause_cnt,
    output gps_chan_pkg::tick_t ticks,
    output logic                ca_resume
);

    logic [11:0] pause_left;
    logic [11:0] pause_nxt;
    logic        borrow;
    logic        armed;

    // Free-running system time
    always_ff @(posedge clk) begin
        if (!rst_n)
            ticks <= '0;
        else
            ticks <= ticks + 1'b1;
    end

    // Borrow out of the count marks the end of the pause
    assign {borrow, pause_nxt} = {1'b0, pause_left} - 13'd1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            armed     <= 1'b0;
            ca_resume <= 1'b0;
        end else begin
            ca_resume <= armed && borrow && !pause_load;
            if (pause_load)
                armed <= 1'b1;
            else if (borrow)
                armed <= 1'b0;
        end
    end

    // Count only while armed, idle otherwise
    always_ff @(posedge clk) begin
        if (pause_load)
            pause_left <= pause_cnt;
        else if (armed)
            pause_left <= pause_nxt;
    end

endmodule

// File: source/gps_demod.sv
`timescale 1ns/1ps

module gps_demod (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   chan_rst,
    input  logic                   sample,
    input  logic                   ca_resume,
    input  logic                   chan_wr,
    input  logic [15:0]            op,
    input  gps_cmd_pkg::cmd_word_u tos,
    input  logic                   chan_shift,
    input  logic                   iq_load,
    output logic                   ms0,
    output logic                   sout
);
    import gps_cmd_pkg::*;
    import gps_chan_pkg::*;

    logic       code_load;
    logic       release_ch;
    logic       loaded;
    logic       running;
    logic [9:0] lfsr;
    logic [5:0] dwell;
    logic [5:0] dwell_cnt;
    logic [9:0] chip_cnt;
    logic       step;
    logic       epoch;
    acc_t       acc;
    acc_t       acc_nxt;
    acc_t       dump;
    acc_t       shift_reg;

    assign code_load  = chan_wr && op[SET_CODE];
    assign release_ch = ca_resume && loaded;

    ////////////////////////////////////////////////////////////
    // Channel state

    // Loaded channels wait for the pause to end
    always_ff @(posedge clk) begin
        if (!rst_n || chan_rst) begin
            loaded  <= 1'b0;
            running <= 1'b0;
            ms0     <= 1'b0;
        end else begin
            ms0 <= epoch;
            if (code_load) begin
                loaded  <= 1'b1;
                running <= 1'b0;
            end else if (release_ch) begin
                loaded  <= 1'b0;
                running <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Code generator

    // One code step per dwell+1 cycles
    assign step  = running && (dwell_cnt == '0);
    assign epoch = step && (chip_cnt == 10'(CODE_LEN - 1));

    always_ff @(posedge clk) begin
        if (code_load) begin
            lfsr  <= tos.code.init;
            dwell <= tos.code.dwell;
        end else if (step) begin
            // x^10 + x^3 + 1
            lfsr <= {lfsr[8:0], lfsr[9] ^ lfsr[2]};
        end
    end

    always_ff @(posedge clk) begin
        if (release_ch) begin
            dwell_cnt <= dwell;
            chip_cnt  <= '0;
        end else if (step) begin
            dwell_cnt <= dwell;
            chip_cnt  <= epoch ? '0 : chip_cnt + 1'b1;
        end else if (running) begin
            dwell_cnt <= dwell_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Integrate and dump

    // Sample agreeing with the code counts up
    assign acc_nxt = (sample ^ lfsr[9]) ? acc - acc_t'(1) : acc + acc_t'(1);

    always_ff @(posedge clk) begin
        if (release_ch)
            acc <= '0;
        else if (step)
            acc <= epoch ? '0 : acc_nxt;
        if (epoch)
            dump <= acc_nxt;
    end

    // Serial readout of the last dump, MSB first
    always_ff @(posedge clk) begin
        if (iq_load)
            shift_reg <= dump;
        else if (chan_shift)
            shift_reg <= shift_reg << 1;
    end

    assign sout = shift_reg[ACC_W-1];

endmodule

// File: source/gps_ser_read.sv
`timescale 1ns/1ps

module gps_ser_read #(
    parameter int GPS_CHANS = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [GPS_CHANS-1:0]  chan_srq,
    input  logic [15:0]           chan_mask,
    input  gps_chan_pkg::tick_t   ticks,
    input  logic [GPS_CHANS-1:0]  chan_sout,
    input  logic [3:0]            cmd_chan,
    input  logic                  srq_load,
    input  logic                  snap_load,
    input  logic                  bit_next,
    input  logic [2:0]            ser_sel,
    output logic                  ser
);
    import gps_cmd_pkg::*;
    import gps_chan_pkg::*;

    localparam int SNAP_W = TICK_W + GPS_CHANS;

    logic [GPS_CHANS-1:0] srq_noted;
    logic [GPS_CHANS-1:0] srq_shift;
    logic [GPS_CHANS-1:0] unserviced;
    logic [SNAP_W-1:0]    snapshot;
    logic [15:0]          sout_all;
    logic [2:0]           ser_data;

    ////////////////////////////////////////////////////////////
    // Service requests

    // Epoch flags collect until the host reads them
    // A flag arriving on the read cycle is kept for the next read
    always_ff @(posedge clk) begin
        if (!rst_n)
            srq_noted <= '0;
        else if (srq_load)
            srq_noted <= chan_srq;
        else
            srq_noted <= srq_noted | chan_srq;
    end

    always_ff @(posedge clk) begin
        if (srq_load)
            srq_shift <= srq_noted & chan_mask[GPS_CHANS-1:0];
        else if (bit_next && ser_sel[GET_SRQ])
            srq_shift <= srq_shift << 1;
    end

    ////////////////////////////////////////////////////////////
    // Snapshot

    // Epochs not yet picked up by a service request read
    assign unserviced = srq_noted | chan_srq;

    always_ff @(posedge clk) begin
        if (snap_load)
            snapshot <= {ticks, unserviced};
        else if (bit_next && ser_sel[GET_SNAPSHOT])
            snapshot <= snapshot << 1;
    end

    ////////////////////////////////////////////////////////////
    // Serial output

    // Unused channel slots read as zero
    assign sout_all = 16'(chan_sout);

    assign ser_data[GET_CHAN_IQ]  = sout_all[cmd_chan];
    assign ser_data[GET_SRQ]      = srq_shift[GPS_CHANS-1];
    assign ser_data[GET_SNAPSHOT] = snapshot[SNAP_W-1];

    // Only one select is expected at a time
    assign ser = |(ser_data & ser_sel);

endmodule

// File: source/gps_core.sv
`timescale 1ns/1ps

module gps_core #(
    parameter int GPS_CHANS = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sample,
    input  logic                   req,
    input  gps_cmd_pkg::cmd_kind_e kind,
    input  logic [15:0]            op,
    input  gps_cmd_pkg::cmd_word_u tos,
    output logic                   ack,
    output logic                   ser
);
    import gps_chan_pkg::*;

    logic [3:0]           cmd_chan;
    logic [15:0]          chan_mask;
    logic                 pause_load;
    logic [11:0]          pause_cnt;
    logic [15:0]          chan_wr;
    logic [15:0]          chan_rst;
    logic [15:0]          chan_shift;
    logic                 srq_load;
    logic                 snap_load;
    logic                 iq_load;
    logic                 bit_next;
    logic [2:0]           ser_sel;
    tick_t                ticks;
    logic                 ca_resume;
    logic [GPS_CHANS-1:0] chan_srq;
    logic [GPS_CHANS-1:0] chan_sout;

    ////////////////////////////////////////////////////////////
    // Host command decode

    gps_host_if u_host_if (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .kind       (kind),
        .op         (op),
        .tos        (tos),
        .ack        (ack),
        .cmd_chan   (cmd_chan),
        .chan_mask  (chan_mask),
        .pause_load (pause_load),
        .pause_cnt  (pause_cnt),
        .chan_wr    (chan_wr),
        .chan_rst   (chan_rst),
        .srq_load   (srq_load),
        .snap_load  (snap_load),
        .iq_load    (iq_load),
        .bit_next   (bit_next),
        .chan_shift (chan_shift),
        .ser_sel    (ser_sel)
    );

    // Tick count and pause release
    gps_timebase u_timebase (
        .clk        (clk),
        .rst_n      (rst_n),
        .pause_load (pause_load),
        .pause_cnt  (pause_cnt),
        .ticks      (ticks),
        .ca_resume  (ca_resume)
    );

    ////////////////////////////////////////////////////////////
    // Demodulator bank

    // Only the low GPS_CHANS steering lines are wired
    for (genvar i = 0; i < GPS_CHANS; i++) begin : g_chan
        gps_demod u_demod (
            .clk        (clk),
            .rst_n      (rst_n),
            .chan_rst   (chan_rst[i]),
            .sample     (sample),
            .ca_resume  (ca_resume),
            .chan_wr    (chan_wr[i]),
            .op         (op),
            .tos        (tos),
            .chan_shift (chan_shift[i]),
            .iq_load    (iq_load),
            .ms0        (chan_srq[i]),
            .sout       (chan_sout[i])
        );
    end

    // Service requests, snapshot and bit mux
    gps_ser_read #(
        .GPS_CHANS (GPS_CHANS)
    ) u_ser_read (
        .clk        (clk),
        .rst_n      (rst_n),
        .chan_srq   (chan_srq),
        .chan_mask  (chan_mask),
        .ticks      (ticks),
        .chan_sout  (chan_sout),
        .cmd_chan   (cmd_chan),
        .srq_load   (srq_load),
        .snap_load  (snap_load),
        .bit_next   (bit_next),
        .ser_sel    (ser_sel),
        .ser        (ser)
    );

endmodule

// File: tests/gps_tb_asserts.sv
`timescale 1ns/1ps

module gps_host_if_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        req,
    input logic        ack,
    input logic [15:0] chan_wr,
    input logic [15:0] chan_rst,
    input logic        pause_load,
    input logic        srq_load,
    input logic        snap_load,
    input logic        iq_load,
    input logic        bit_next
);

    logic any_stb;

    // Any strobe toward the other blocks
    assign any_stb = pause_load | srq_load | snap_load | iq_load | bit_next
                   | (|chan_wr) | (|chan_rst);

    ////////////////////////////////////////////////////////////
    // Handshake

    // Ack only answers a pending request, one cycle after its strobe set
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req) && $past(any_stb))
        else $error("ack rose without a request strobe before it");

    ack_low_after_reset: assert property (@(posedge clk) !rst_n |=> !ack)
        else $error("ack high right after reset");

    ////////////////////////////////////////////////////////////
    // Strobes

    strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        any_stb |=> !any_stb)
        else $error("strobe held longer than one cycle");

    // Channel writes go to a single channel
    chan_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(chan_wr))
        else $error("more than one chan_wr line set");

endmodule

bind gps_host_if gps_host_if_asserts u_host_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .ack        (ack),
    .chan_wr    (chan_wr),
    .chan_rst   (chan_rst),
    .pause_load (pause_load),
    .srq_load   (srq_load),
    .snap_load  (snap_load),
    .iq_load    (iq_load),
    .bit_next   (bit_next)
);

// File: tests/gps_tb.sv
`timescale 1ns/1ps

module gps_tb;
    import gps_cmd_pkg::*;
    import gps_chan_pkg::*;

    localparam int GPS_CHANS = 4;
    localparam int SNAP_W = TICK_W + GPS_CHANS;
    localparam int WATCHDOG_CYCLES = 20 * CODE_LEN * 64;
    localparam int PAUSE = 100;
    localparam int D0 = 0;
    localparam int D1 = 1;
    // Cycles per epoch for the two running channels
    localparam int L0 = CODE_LEN * (D0 + 1);
    localparam int L1 = CODE_LEN * (D1 + 1);
    localparam logic [9:0] INIT0 = 10'h2A5;
    localparam logic [9:0] INIT1 = 10'h1C3;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        sample;
    logic        req;
    cmd_kind_e   kind;
    logic [15:0] op;
    cmd_word_u   tos;
    logic        ack;
    logic        ser;

    integer      seed;
    integer      rnd;
    int          cyc = 0;
    int          rst_cyc;
    int          ack_cyc;
    int          load_cyc;
    int          rel;
    int          n_checks = 0;
    int          n_errors = 0;
    logic        ser_bit;
    logic [63:0] rd_word;
    // Entry n-1 is the sample seen at rising edge n
    logic        samp_q[$];

    gps_core #(
        .GPS_CHANS (GPS_CHANS)
    ) dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .req    (req),
        .kind   (kind),
        .op     (op),
        .tos    (tos),
        .ack    (ack),
        .ser    (ser)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cyc = cyc + 1;

    // Random sign samples, one per cycle
    always @(negedge clk) begin
        rnd = $random(seed);
        sample = rnd[0];
        samp_q.push_back(rnd[0]);
    end

    ////////////////////////////////////////////////////////////
    // Host driver

    function automatic logic [15:0] op_bit(input int pos);
        return 16'b1 << pos;
    endfunction

    function automatic cmd_word_u sel_word(input logic [3:0] chan, input logic [15:0] mask,
                                           input logic [11:0] pause);
        cmd_word_u w;
        w = '0;
        w.sel.chan  = chan;
        w.sel.mask  = mask;
        w.sel.pause = pause;
        return w;
    endfunction

    function automatic cmd_word_u code_word(input logic [9:0] init, input logic [5:0] dwell);
        cmd_word_u w;
        w = '0;
        w.code.init  = init;
        w.code.dwell = dwell;
        return w;
    endfunction

    // One full four-phase transfer, ser sampled while ack is high
    task automatic do_cmd(input cmd_kind_e k, input logic [15:0] o, input cmd_word_u w);
        @(negedge clk);
        kind = k;
        op   = o;
        tos  = w;
        req  = 1'b1;
        @(posedge ack);
        @(negedge clk);
        ack_cyc = cyc;
        ser_bit = ser;
        req = 1'b0;
        @(negedge ack);
    endtask

    // MSB first into the low end of rd_word
    task automatic read_bits(input logic [15:0] o, input int n);
        rd_word = '0;
        do_cmd(rd_reg, o, '0);
        // Edge on which the read register was loaded
        load_cyc = ack_cyc;
        rd_word = {rd_word[62:0], ser_bit};
        for (int i = 1; i < n; i++) begin
            do_cmd(rd_bit, o, '0);
            rd_word = {rd_word[62:0], ser_bit};
        end
    endtask

    task automatic select_chan(input logic [3:0] chan);
        do_cmd(wr_reg, op_bit(SET_CHAN), sel_word(chan, 16'd0, 12'd0));
    endtask

    task automatic write_mask(input logic [15:0] mask);
        do_cmd(wr_reg, op_bit(SET_MASK), sel_word(4'd0, mask, 12'd0));
    endtask

    task automatic start_pause(input int p);
        do_cmd(wr_reg, op_bit(SET_PAUSE), sel_word(4'd0, 16'd0, 12'(p)));
    endtask

    task automatic load_code(input logic [3:0] chan, input logic [9:0] init, input int dwell);
        select_chan(chan);
        do_cmd(wr_reg, op_bit(SET_CODE), code_word(init, 6'(dwell)));
    endtask

    task automatic wait_until(input int n);
        while (cyc < n)
            @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model

    // Sum over the last of epoch_n epochs of a channel released at edge rel
    function automatic acc_t ref_corr(input logic [9:0] init, input int dwell,
                                      input int start, input int epoch_n);
        logic [9:0] state;
        acc_t       sum;
        int         n;
        state = init;
        sum = '0;
        for (int m = 1; m <= epoch_n * CODE_LEN; m++) begin
            // Code step m lands on this rising edge
            n = start + m * (dwell + 1);
            if (m > (epoch_n - 1) * CODE_LEN) begin
                if (samp_q[n - 1] ^ state[9])
                    sum = sum - acc_t'(1);
                else
                    sum = sum + acc_t'(1);
            end
            // Maximal 10 bit sequence, taps 10 and 3
            state = {state[8:0], state[9] ^ state[2]};
        end
        return sum;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_word(input string what, input logic [GPS_CHANS-1:0] got,
                              input logic [GPS_CHANS-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: %s flags %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_acc(input string what, input acc_t got, input acc_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: %s sum %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_tick(input string what, input tick_t got, input tick_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: %s ticks %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: a handshake or wait never finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        seed   = 97415;
        rst_n  = 1'b0;
        req    = 1'b0;
        kind   = wr_reg;
        op     = '0;
        tos    = '0;
        sample = 1'b0;
        samp_q.push_back(1'b0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        rst_cyc = cyc;

        // Nothing pending out of reset
        read_bits(op_bit(GET_SRQ), GPS_CHANS);
        check_word("srq after reset", rd_word[GPS_CHANS-1:0], '0);

        // Channel 1 unmasked, channel 0 masked off
        write_mask(16'h0002);
        load_code(4'd0, INIT0, D0);
        load_code(4'd1, INIT1, D1);
        start_pause(PAUSE);
        // Resume pulse P+1 edges after the load, release on the edge after it
        rel = ack_cyc + PAUSE + 2;

        // Snapshot loads a few edges before the first channel 0 epoch
        wait_until(rel + L0 - 6);
        read_bits(op_bit(GET_SNAPSHOT), SNAP_W);
        check_word("snapshot before epoch", rd_word[GPS_CHANS-1:0], '0);
        check_tick("snapshot before epoch", rd_word[SNAP_W-1:GPS_CHANS],
                   tick_t'(load_cyc - rst_cyc - 1));

        // Past the first channel 0 epoch, before the first channel 1 epoch
        wait_until(rel + L0 + 20);
        read_bits(op_bit(GET_SNAPSHOT), SNAP_W);
        check_word("snapshot after epoch", rd_word[GPS_CHANS-1:0], 4'b0001);
        check_tick("snapshot after epoch", rd_word[SNAP_W-1:GPS_CHANS],
                   tick_t'(load_cyc - rst_cyc - 1));

        // Only the unmasked flag comes out, and the read clears it
        wait_until(rel + L1 + 20);
        read_bits(op_bit(GET_SRQ), GPS_CHANS);
        check_word("masked srq", rd_word[GPS_CHANS-1:0], 4'b0010);
        read_bits(op_bit(GET_SRQ), GPS_CHANS);
        check_word("srq reread", rd_word[GPS_CHANS-1:0], '0);

        // Last dump of each channel against the model
        select_chan(4'd0);
        read_bits(op_bit(GET_CHAN_IQ), ACC_W);
        check_acc("chan 0 IQ", acc_t'(rd_word[ACC_W-1:0]),
                  ref_corr(INIT0, D0, rel, (load_cyc - 1 - rel) / L0));
        select_chan(4'd1);
        read_bits(op_bit(GET_CHAN_IQ), ACC_W);
        check_acc("chan 1 IQ", acc_t'(rd_word[ACC_W-1:0]),
                  ref_corr(INIT1, D1, rel, (load_cyc - 1 - rel) / L1));

        // Reset hits channel 1 only, channel 0 keeps running
        do_cmd(wr_evt, op_bit(CHAN_RST), '0);
        read_bits(op_bit(GET_SRQ), GPS_CHANS);
        write_mask(16'h0003);
        wait_until(ack_cyc + 2 * L1 + 50);
        read_bits(op_bit(GET_SRQ), GPS_CHANS);
        check_word("srq after chan reset", rd_word[GPS_CHANS-1:0], 4'b0001);

        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: flist.f
source/gps_cmd_pkg.sv
source/gps_chan_pkg.sv
source/gps_host_if.sv
source/gps_timebase.sv
source/gps_demod.sv
source/gps_ser_read.sv
source/gps_core.sv
tests/gps_tb_asserts.sv
tests/gps_tb.sv

// File: Makefile
SRCS := $(wildcard source/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vgps_tb: flist.f $(SRCS)
	verilator --binary --timing --assert --top-module gps_tb -f flist.f -o Vgps_tb

run: obj_dir/Vgps_tb
	./obj_dir/Vgps_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
